// File: run.sh
#!/usr/bin/env bash
# build and run the cpu testbench, exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpuTb -f src.f \
    && ./obj_dir/VcpuTb \
    && echo "simulation finished" \
    || { echo "simulation failed"; exit 1; }

// File: source/alu.sv
module alu import mipsPkg::*; (
    input  logic [dataWidth-1:0] a,
    input  logic [dataWidth-1:0] b,
    input  aluOpE                aluOp,
    output logic [dataWidth-1:0] result,
    output logic [dataWidth-1:0] nFlag
);

    localparam int shamtBits = $clog2(dataWidth);

    logic [dataWidth-1:0] sum;
    logic [dataWidth-1:0] diff;
    logic [shamtBits-1:0] shamt;
    logic lessThan;
    logic addOverflow;

    assign sum = a + b;
    assign diff = a - b;
    assign shamt = a[shamtBits-1:0]; // srav takes the amount from rs.
    assign lessThan = $signed(a) < $signed(b);

    // same operand signs but the sum flipped.
    assign addOverflow = (a[dataWidth-1] == b[dataWidth-1])
                      && (sum[dataWidth-1] != a[dataWidth-1]);

    always_comb begin
        case (aluOp)
            aluAdd:  result = sum;
            aluSub:  result = diff;
            aluOr:   result = a | b;
            aluSlt:  result = {{(dataWidth - 1){1'b0}}, lessThan};
            aluSra:  result = $signed(b) >>> shamt; // sign fill.
            default: result = '0;
        endcase
    end

    always_comb begin
        nFlag = '0;
        nFlag[flagBitZero] = (result == '0);
        nFlag[flagBitOverflow] = (aluOp == aluAdd) && addOverflow;
    end

endmodule

// File: source/controller.sv
module controller import mipsPkg::*; (
    input  opcodeE               opcode,
    input  functE                funct,
    input  logic [dataWidth-1:0] nFlag,
    output regDstE               regDst,
    output aluSrcE               aluSrc,
    output mem2RegE              mem2Reg,
    output logic                 regWr,
    output logic                 memWr,
    output npcSelE               npcSel,
    output extOpE                extOp,
    output aluOpE                aluOp,
    output flagOpE               flagOp
);

    typedef struct packed {
        regDstE  regDst;
        aluSrcE  aluSrc;
        mem2RegE mem2Reg;
        logic    regWr;
        logic    memWr;
        npcSelE  npcSel;
        extOpE   extOp;
        aluOpE   aluOp;
        flagOpE  flagOp;
    } ctrlT;

    // no writes, sequential pc.
    localparam ctrlT ctrlOff = '{dstRt, srcB, wbAlu, 1'b0, 1'b0, npcPc4, extZero, aluAdd, flagHold};

    ctrlT cw;
    logic zero;
    logic overflow;

    assign zero = nFlag[flagBitZero];
    assign overflow = nFlag[flagBitOverflow];

    // opcode and funct only. the flag dependent fields are gated further down.
    always_comb begin
        cw = ctrlOff;
        case (opcode)
            opSpecial: begin
                case (funct)
                    fnAddu: cw = '{dstRd, srcB, wbAlu, 1'b1, 1'b0, npcPc4, extZero, aluAdd, flagHold};
                    fnSubu: cw = '{dstRd, srcB, wbAlu, 1'b1, 1'b0, npcPc4, extZero, aluSub, flagHold};
                    fnSlt:  cw = '{dstRd, srcB, wbAlu, 1'b1, 1'b0, npcPc4, extZero, aluSlt, flagHold};
                    fnSrav: cw = '{dstRd, srcB, wbAlu, 1'b1, 1'b0, npcPc4, extZero, aluSra, flagHold};
                    fnJr:   cw = '{dstRt, srcB, wbAlu, 1'b0, 1'b0, npcReg, extZero, aluAdd, flagHold};
                    fnNop:  cw = ctrlOff;
                    default: cw = ctrlOff;
                endcase
            end
            opOri:   cw = '{dstRt, srcImm, wbAlu, 1'b1, 1'b0, npcPc4, extZero, aluOr, flagHold};
            opLui:   cw = '{dstRt, srcImm, wbAlu, 1'b1, 1'b0, npcPc4, extLui, aluOr, flagHold};
            opAddi:  cw = '{dstRt, srcImm, wbAlu, 1'b1, 1'b0, npcPc4, extSign, aluAdd, flagSet};
            opAddiu: cw = '{dstRt, srcImm, wbAlu, 1'b1, 1'b0, npcPc4, extSign, aluAdd, flagHold};
            opLw:    cw = '{dstRt, srcImm, wbRam, 1'b1, 1'b0, npcPc4, extSign, aluAdd, flagHold};
            opSw:    cw = '{dstRt, srcImm, wbRam, 1'b0, 1'b1, npcPc4, extSign, aluAdd, flagHold};
            opBeq:   cw = '{dstRt, srcB, wbAlu, 1'b0, 1'b0, npcBranch, extZero, aluSub, flagHold};
            opJ:     cw = '{dstRt, srcB, wbAlu, 1'b0, 1'b0, npcJump, extZero, aluAdd, flagHold};
            opJal:   cw = '{dstRa, srcB, wbPc4, 1'b1, 1'b0, npcJump, extZero, aluAdd, flagHold};
            default: cw = ctrlOff;
        endcase
    end

    assign regDst = cw.regDst;
    assign aluSrc = cw.aluSrc;
    assign mem2Reg = cw.mem2Reg;
    assign regWr = cw.regWr;
    assign memWr = cw.memWr;
    assign extOp = cw.extOp;
    assign aluOp = cw.aluOp;

    // beq stays sequential unless rs equals rt.
    assign npcSel = (cw.npcSel == npcBranch && !zero) ? npcPc4 : cw.npcSel;

    // addi only raises the status bit on an actual overflow.
    assign flagOp = (cw.flagOp == flagSet && overflow) ? flagSet : flagHold;

endmodule

// File: source/cpuTop.sv
module cpuTop import mipsPkg::*; #(
    parameter logic [31:0] resetPc = 32'h0000_3000,
    parameter int dmemWords = 1024
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [31:0]             instr,
    output logic [31:0]             pc,
    output logic                    regWrEn,
    output logic [regAddrWidth-1:0] regWrAddr,
    output logic [dataWidth-1:0]    regWrData,
    output logic                    memWrEn,
    output logic [dataWidth-1:0]    memAddr,
    output logic [dataWidth-1:0]    memWrData,
    output logic                    ovfFlag
);

    opcodeE opcode;
    functE funct;
    regDstE regDst;
    aluSrcE aluSrc;
    mem2RegE mem2Reg;
    npcSelE npcSel;
    extOpE extOp;
    aluOpE aluOp;
    flagOpE flagOp;

    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [15:0] imm16;
    logic [dataWidth-1:0] extImm;
    logic [dataWidth-1:0] rdDataA;
    logic [dataWidth-1:0] rdDataB;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] nFlag;
    logic [dataWidth-1:0] ramData;
    logic [31:0] pcPlus4;

    assign opcode = opcodeE'(instr[31:26]);
    assign funct = functE'(instr[5:0]);
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign imm16 = instr[15:0];

    controller u_controller (
        .opcode(opcode), .funct(funct), .nFlag(nFlag),
        .regDst(regDst), .aluSrc(aluSrc), .mem2Reg(mem2Reg),
        .regWr(regWrEn), .memWr(memWrEn), .npcSel(npcSel),
        .extOp(extOp), .aluOp(aluOp), .flagOp(flagOp)
    );

    always_comb begin
        case (extOp)
            extZero: extImm = {16'b0, imm16};
            extSign: extImm = {{16{imm16[15]}}, imm16};
            extLui:  extImm = {imm16, 16'b0};
            default: extImm = '0;
        endcase
    end

    assign aluB = (aluSrc == srcImm) ? extImm : rdDataB;

    alu u_alu (.a(rdDataA), .b(aluB), .aluOp(aluOp), .result(aluResult), .nFlag(nFlag));

    always_comb begin
        case (regDst)
            dstRd:   regWrAddr = rd;
            dstRa:   regWrAddr = regAddrWidth'(raReg);
            default: regWrAddr = rt;
        endcase
    end

    always_comb begin
        case (mem2Reg)
            wbRam:   regWrData = ramData;
            wbPc4:   regWrData = pcPlus4; // jal link.
            default: regWrData = aluResult;
        endcase
    end

    regFile u_regFile (
        .clk(clk), .arstN(arstN), .rdAddrA(rs), .rdAddrB(rt),
        .wrEn(regWrEn), .wrAddr(regWrAddr), .wrData(regWrData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    nextPc #(.resetPc(resetPc)) u_nextPc (
        .clk(clk), .arstN(arstN), .npcSel(npcSel), .imm16(imm16),
        .target26(instr[25:0]), .regTarget(rdDataA), .pc(pc), .pcPlus4(pcPlus4)
    );

    assign memAddr = aluResult;
    assign memWrData = rdDataB;

    dataMem #(.dmemWords(dmemWords)) u_dataMem (
        .clk(clk), .wrEn(memWrEn), .addr(memAddr), .wrData(memWrData), .rdData(ramData)
    );

    // sticky until reset.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ovfFlag <= 1'b0;
        end else if (flagOp == flagSet) begin
            ovfFlag <= 1'b1;
        end
    end

endmodule

// File: source/dataMem.sv
module dataMem import mipsPkg::*; #(
    parameter int dmemWords = 1024
) (
    input  logic                 clk,
    input  logic                 wrEn,
    input  logic [dataWidth-1:0] addr,
    input  logic [dataWidth-1:0] wrData,
    output logic [dataWidth-1:0] rdData
);

    localparam int idxBits = (dmemWords > 1) ? $clog2(dmemWords) : 1;

    logic [dataWidth-1:0] mem [dmemWords];
    logic [idxBits-1:0] wordIdx;

    // byte address to word index wrapping at the array size.
    assign wordIdx = idxBits'(32'(addr[dataWidth-1:2]) % dmemWords);

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx]; // async read.

endmodule

// File: source/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int raReg = 31; // link register for jal.

    // bit positions inside the alu flag word.
    localparam int flagBitZero = 0;
    localparam int flagBitOverflow = 1;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opAddi    = 6'h08,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeE;

    // funct field of special instructions.
    typedef enum logic [5:0] {
        fnNop  = 6'h00, // sll, treated as nop.
        fnSrav = 6'h07,
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnSlt  = 6'h2a
    } functE;

    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstE;

    typedef enum logic {srcB, srcImm} aluSrcE;

    typedef enum logic [1:0] {wbAlu, wbRam, wbPc4} mem2RegE;

    typedef enum logic [1:0] {npcPc4, npcBranch, npcJump, npcReg} npcSelE;

    typedef enum logic [1:0] {extZero, extSign, extLui} extOpE;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluSlt,
        aluSra
    } aluOpE;

    typedef enum logic {flagHold, flagSet} flagOpE;

endpackage

// File: source/nextPc.sv
module nextPc import mipsPkg::*; #(
    parameter logic [31:0] resetPc = 32'h0000_3000
) (
    input  logic        clk,
    input  logic        arstN,
    input  npcSelE      npcSel,
    input  logic [15:0] imm16,
    input  logic [25:0] target26,
    input  logic [31:0] regTarget,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4
);

    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] pcNext;

    assign pcPlus4 = pc + 32'd4;

    // word offset relative to the delay slot address.
    assign branchTarget = pcPlus4 + {{14{imm16[15]}}, imm16, 2'b00};
    assign jumpTarget = {pc[31:28], target26, 2'b00};

    always_comb begin
        case (npcSel)
            npcPc4:    pcNext = pcPlus4;
            npcBranch: pcNext = branchTarget;
            npcJump:   pcNext = jumpTarget;
            npcReg:    pcNext = regTarget;
            default:   pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// File: source/regFile.sv
module regFile import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rdAddrA,
    input  logic [regAddrWidth-1:0] rdAddrB,
    input  logic                    wrEn,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0]    wrData,
    output logic [dataWidth-1:0]    rdDataA,
    output logic [dataWidth-1:0]    rdDataB
);

    localparam int numRegs = 2 ** regAddrWidth;

    logic [dataWidth-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // $zero reads as zero.
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

// File: src.f
source/mipsPkg.sv
source/alu.sv
source/controller.sv
source/regFile.sv
source/nextPc.sv
source/dataMem.sv
source/cpuTop.sv
tb/cpuTb_assert.sv
tb/cpuTb.sv

// File: tb/cpuTb.sv
module cpuTb import mipsPkg::*; ;

    localparam logic [31:0] resetPc = 32'h0000_3000;
    localparam int dmemWords = 256;
    localparam int progLen = 30;
    localparam int watchdogCycles = 200;
    localparam logic [31:0] nop = 32'h0000_0000;

    typedef struct packed {
        logic [31:0] pc;
        logic regWr;
        logic [regAddrWidth-1:0] regAddr;
        logic [dataWidth-1:0] regData;
        logic memWr;
        logic [dataWidth-1:0] memAddr;
        logic [dataWidth-1:0] memData;
        logic ovf;
    } stepT;

    logic clk;
    logic arstN;
    logic [31:0] instr;
    logic [31:0] pc;
    logic regWrEn;
    logic [regAddrWidth-1:0] regWrAddr;
    logic [dataWidth-1:0] regWrData;
    logic memWrEn;
    logic [dataWidth-1:0] memAddr;
    logic [dataWidth-1:0] memWrData;
    logic ovfFlag;

    logic [31:0] progMem [progLen];
    logic [31:0] fetchIdx;
    stepT steps [$];
    int errCount;

    cpuTop #(.resetPc(resetPc), .dmemWords(dmemWords)) dut0 (
        .clk(clk), .arstN(arstN), .instr(instr), .pc(pc),
        .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
        .memWrEn(memWrEn), .memAddr(memAddr), .memWrData(memWrData), .ovfFlag(ovfFlag)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // instruction memory, nop while in reset or off the end.
    always_comb begin
        fetchIdx = (pc - resetPc) >> 2;
        if (!arstN || fetchIdx >= 32'(progLen)) begin
            instr = nop;
        end else begin
            instr = progMem[fetchIdx[4:0]];
        end
    end

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input functE fn);
        return {opSpecial, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encI(input opcodeE op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(input opcodeE op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] addrOf(input int idx);
        return resetPc + 32'(idx * 4);
    endfunction

    task automatic loadProgram();
        progMem[0] = encI(opLui, 5'd0, 5'd1, 16'h1234);
        progMem[1] = encI(opOri, 5'd1, 5'd1, 16'h5678);
        progMem[2] = encI(opOri, 5'd0, 5'd2, 16'h0005);
        progMem[3] = encI(opOri, 5'd0, 5'd3, 16'h0003);
        progMem[4] = encR(5'd2, 5'd3, 5'd4, fnAddu);
        progMem[5] = encR(5'd3, 5'd2, 5'd5, fnSubu);
        progMem[6] = encR(5'd5, 5'd2, 5'd6, fnSlt); // -2 < 5.
        progMem[7] = encI(opLui, 5'd0, 5'd7, 16'h8000);
        progMem[8] = encI(opOri, 5'd0, 5'd8, 16'h0004);
        progMem[9] = encR(5'd8, 5'd7, 5'd9, fnSrav);
        progMem[10] = encI(opSw, 5'd0, 5'd1, 16'h0010);
        progMem[11] = encI(opLw, 5'd0, 5'd10, 16'h0010);
        progMem[12] = encI(opBeq, 5'd1, 5'd10, 16'h0002); // taken, lands on 15.
        progMem[13] = encI(opOri, 5'd0, 5'd11, 16'hdead);
        progMem[14] = encI(opOri, 5'd0, 5'd11, 16'hdead);
        progMem[15] = encI(opBeq, 5'd1, 5'd2, 16'h0005);
        progMem[16] = encJ(opJ, addrOf(18));
        progMem[17] = encI(opOri, 5'd0, 5'd11, 16'hdead);
        progMem[18] = encJ(opJal, addrOf(21));
        progMem[19] = encI(opOri, 5'd0, 5'd12, 16'h0077);
        progMem[20] = encJ(opJ, addrOf(23));
        progMem[21] = encI(opOri, 5'd0, 5'd13, 16'h0001); // subroutine.
        progMem[22] = encR(5'd31, 5'd0, 5'd0, fnJr);
        progMem[23] = encI(opLui, 5'd0, 5'd14, 16'h7fff);
        progMem[24] = encI(opOri, 5'd14, 5'd14, 16'hffff);
        progMem[25] = encI(opAddiu, 5'd14, 5'd15, 16'h0001);
        progMem[26] = encI(opAddi, 5'd14, 5'd16, 16'h0001);
        progMem[27] = encI(opOri, 5'd0, 5'd17, 16'h0042);
        progMem[28] = encR(5'd15, 5'd16, 5'd18, fnAddu); // wraps, flag untouched.
        progMem[29] = nop;
    endtask

    task automatic expWrite(input int idx, input logic [4:0] addr, input logic [31:0] data,
                            input logic ovf);
        stepT s;
        s = '0;
        s.pc = addrOf(idx);
        s.regWr = 1'b1;
        s.regAddr = addr;
        s.regData = data;
        s.ovf = ovf;
        steps.push_back(s);
    endtask

    task automatic expStore(input int idx, input logic [31:0] addr, input logic [31:0] data);
        stepT s;
        s = '0;
        s.pc = addrOf(idx);
        s.memWr = 1'b1;
        s.memAddr = addr;
        s.memData = data;
        steps.push_back(s);
    endtask

    task automatic expIdle(input int idx, input logic ovf);
        stepT s;
        s = '0;
        s.pc = addrOf(idx);
        s.ovf = ovf;
        steps.push_back(s);
    endtask

    // execution order, with the expected result of each step.
    task automatic loadSteps();
        expWrite(0, 5'd1, 32'h1234_0000, 1'b0);
        expWrite(1, 5'd1, 32'h1234_5678, 1'b0);
        expWrite(2, 5'd2, 32'h0000_0005, 1'b0);
        expWrite(3, 5'd3, 32'h0000_0003, 1'b0);
        expWrite(4, 5'd4, 32'h0000_0008, 1'b0);
        expWrite(5, 5'd5, 32'hffff_fffe, 1'b0);
        expWrite(6, 5'd6, 32'h0000_0001, 1'b0);
        expWrite(7, 5'd7, 32'h8000_0000, 1'b0);
        expWrite(8, 5'd8, 32'h0000_0004, 1'b0);
        expWrite(9, 5'd9, 32'hf800_0000, 1'b0);
        expStore(10, 32'h0000_0010, 32'h1234_5678);
        expWrite(11, 5'd10, 32'h1234_5678, 1'b0);
        expIdle(12, 1'b0);
        expIdle(15, 1'b0);
        expIdle(16, 1'b0);
        expWrite(18, 5'd31, addrOf(19), 1'b0);
        expWrite(21, 5'd13, 32'h0000_0001, 1'b0);
        expIdle(22, 1'b0);
        expWrite(19, 5'd12, 32'h0000_0077, 1'b0);
        expIdle(20, 1'b0);
        expWrite(23, 5'd14, 32'h7fff_0000, 1'b0);
        expWrite(24, 5'd14, 32'h7fff_ffff, 1'b0);
        expWrite(25, 5'd15, 32'h8000_0000, 1'b0);
        expWrite(26, 5'd16, 32'h8000_0000, 1'b0); // flag rises after this edge.
        expWrite(27, 5'd17, 32'h0000_0042, 1'b1);
        expWrite(28, 5'd18, 32'h0000_0000, 1'b1);
        expIdle(29, 1'b1);
        expIdle(30, 1'b1);
    endtask

    task automatic stopRun();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errCount++;
            stopRun();
        end
    endtask

    task automatic checkStep(input int idx);
        stepT s;
        s = steps[idx];
        checkValue("pc", pc, s.pc);
        checkValue("regWrEn", 32'(regWrEn), 32'(s.regWr));
        if (s.regWr) begin
            checkValue("regWrAddr", 32'(regWrAddr), 32'(s.regAddr));
            checkValue("regWrData", regWrData, s.regData);
        end
        checkValue("memWrEn", 32'(memWrEn), 32'(s.memWr));
        if (s.memWr) begin
            checkValue("memAddr", memAddr, s.memAddr);
            checkValue("memWrData", memWrData, s.memData);
        end
        checkValue("ovfFlag", 32'(ovfFlag), 32'(s.ovf));
    endtask

    initial begin
        int stepIdx;
        int cycles;
        arstN = 1'b0;
        errCount = 0;
        loadProgram();
        loadSteps();
        for (int n = 0; n < 4; n++) begin
            @(posedge clk);
        end
        arstN <= 1'b1;
        stepIdx = 0;
        cycles = 0;
        // sample mid cycle, one instruction per clock.
        while (stepIdx < steps.size() && cycles < watchdogCycles) begin
            @(negedge clk);
            checkStep(stepIdx);
            stepIdx++;
            cycles++;
        end
        if (stepIdx < steps.size()) begin
            $display("timeout: only %0d of %0d steps were checked", stepIdx, steps.size());
            errCount++;
        end
        if (errCount == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stopRun();
        end
    end

    initial begin
        for (int n = 0; n < watchdogCycles + 20; n++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within %0d cycles", watchdogCycles + 20);
        stopRun();
    end

endmodule

// File: tb/cpuTb_assert.sv
module cpuTbAssert import mipsPkg::*; (
    input logic                    clk,
    input logic                    arstN,
    input logic [31:0]             pc,
    input logic                    regWrEn,
    input logic [regAddrWidth-1:0] regWrAddr,
    input logic [dataWidth-1:0]    regWrData,
    input logic                    ovfFlag
);

    // $zero only ever sees zero data.
    zeroRegWrite: assert property (@(posedge clk) disable iff (!arstN)
        (regWrEn && regWrAddr == '0) |-> (regWrData == '0))
        else $error("nonzero write to register 0");

    pcAligned: assert property (@(posedge clk) disable iff (!arstN)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    ovfSticky: assert property (@(posedge clk) disable iff (!arstN)
        !$fell(ovfFlag))
        else $error("overflow status cleared outside reset");

endmodule

bind cpuTop cpuTbAssert u_cpuTbAssert (
    .clk(clk), .arstN(arstN), .pc(pc), .regWrEn(regWrEn),
    .regWrAddr(regWrAddr), .regWrData(regWrData), .ovfFlag(ovfFlag)
);
